//--- src/clkmgr_macros.svh
`ifndef CLKMGR_MACROS_SVH
`define CLKMGR_MACROS_SVH

// APB register bus
`define CLKMGR_ADDR_W 8
`define CLKMGR_DATA_W 16

// Signed fine phase position of the ADC generator
`define PHASE_W 16

// Generator reconfiguration port
`define DRP_ADDR_W 7
`define DRP_DATA_W 16

// Generator reset hold after a clock source change, in clk_usb cycles
`define SEL_HOLD_CYCLES 8

`endif

//--- src/clkmgr_pkg.sv
`include "clkmgr_macros.svh"

package clkmgr_pkg;

    typedef struct packed {
        logic [`CLKMGR_ADDR_W-1:0] paddr;
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [`CLKMGR_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`CLKMGR_DATA_W-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // Bit order matches REG_CTRL, adc_source in the low bits
    typedef struct packed {
        logic       mmcm_shutdown;
        logic       gen_power_down;
        logic       adc_power_down;
        logic       gen_source;
        logic [2:0] adc_source;     // Same encoding as the ADC clock select bits
    } clk_ctrl_t;

    typedef struct packed {
        logic [`DRP_ADDR_W-1:0] daddr;
        logic                   den;
        logic                   dwe;
        logic [`DRP_DATA_W-1:0] di;
    } drp_req_t;

    typedef struct packed {
        logic [`DRP_DATA_W-1:0] dout;
        logic                   drdy;
    } drp_rsp_t;

    typedef struct packed {
        logic psen;
        logic psincdec;     // 1 steps the phase up
    } ps_req_t;

    typedef enum logic [`CLKMGR_ADDR_W-1:0] {
        REG_CTRL     = 8'h00,
        REG_PHASE    = 8'h04,
        REG_STATUS   = 8'h08,
        REG_DRP_ADDR = 8'h0C,
        REG_DRP_DATA = 8'h10,
        REG_DRP_CMD  = 8'h14
    } reg_addr_e;

    typedef enum logic [1:0] {PS_IDLE, PS_STEP, PS_WAIT} phase_state_e;

    typedef enum logic [1:0] {DRP_IDLE, DRP_WAIT_WR, DRP_WAIT_RD} drp_state_e;

endpackage

//--- src/clkmgr_regs.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module clkmgr_regs import clkmgr_pkg::*; (
    input  logic                   clk_usb,
    input  logic                   rst,
    input  apb_req_t               apb_req,
    output apb_rsp_t               apb_rsp,
    input  logic                   phase_done,
    input  logic                   drp_busy,
    input  logic                   adc_locked,
    input  logic                   gen_locked,
    input  logic [`DRP_DATA_W-1:0] drp_rdata,
    output clk_ctrl_t              ctrl,
    output logic [`PHASE_W-1:0]    phase_target,
    output logic [`DRP_ADDR_W-1:0] drp_addr,
    output logic [`DRP_DATA_W-1:0] drp_wdata,
    output logic                   drp_wr_start,
    output logic                   drp_rd_start,
    output logic                   drp_reset
);

    reg_addr_e                 reg_addr;
    logic                      access;      // APB access phase
    logic                      addr_hit;
    logic                      drp_reg;     // Offset starts a DRP transaction
    logic                      err;
    logic                      wr_ok;
    logic [`CLKMGR_DATA_W-1:0] rdata;

    assign reg_addr = reg_addr_e'(apb_req.paddr);
    assign access   = apb_req.psel & apb_req.penable;

    // Address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        drp_reg  = 1'b0;
        rdata    = '0;
        case (reg_addr)
            REG_CTRL:     rdata[$bits(clk_ctrl_t)-1:0] = ctrl;
            REG_PHASE:    rdata[`PHASE_W-1:0] = phase_target;
            REG_STATUS:   rdata[3:0] = {gen_locked, adc_locked, drp_busy, phase_done};
            REG_DRP_ADDR: rdata[`DRP_ADDR_W-1:0] = drp_addr;
            REG_DRP_DATA: begin
                rdata[`DRP_DATA_W-1:0] = drp_rdata;    // Last word read back
                drp_reg = 1'b1;
            end
            REG_DRP_CMD: begin
                rdata[1] = drp_reset;
                drp_reg  = 1'b1;
            end
            default:      addr_hit = 1'b0;
        endcase
    end

    // Unmapped offset, or a DRP command while the bridge is still working
    assign err   = access & (~addr_hit | (apb_req.pwrite & drp_reg & drp_busy));
    assign wr_ok = access & apb_req.pwrite & ~err;

    always_comb begin
        apb_rsp = '{prdata: rdata, pready: 1'b1, pslverr: err};
    end

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            ctrl         <= '0;
            phase_target <= '0;
            drp_wr_start <= 1'b0;
            drp_rd_start <= 1'b0;
            drp_reset    <= 1'b0;
        end else begin
            drp_wr_start <= wr_ok & (reg_addr == REG_DRP_DATA);
            drp_rd_start <= wr_ok & (reg_addr == REG_DRP_CMD) & apb_req.pwdata[0];
            if (wr_ok) begin
                case (reg_addr)
                    REG_CTRL:    ctrl <= clk_ctrl_t'(apb_req.pwdata[$bits(clk_ctrl_t)-1:0]);
                    REG_PHASE:   phase_target <= apb_req.pwdata[`PHASE_W-1:0];
                    REG_DRP_CMD: drp_reset <= apb_req.pwdata[1];    // Held until cleared
                    default:     ;
                endcase
            end
        end
    end

    // DRP address and write word
    always_ff @(posedge clk_usb) begin
        if (wr_ok && reg_addr == REG_DRP_ADDR) begin
            drp_addr <= apb_req.pwdata[`DRP_ADDR_W-1:0];
        end
        if (wr_ok && reg_addr == REG_DRP_DATA) begin
            drp_wdata <= apb_req.pwdata[`DRP_DATA_W-1:0];
        end
    end

endmodule

//--- src/phase_shift_ctrl.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module phase_shift_ctrl import clkmgr_pkg::*; (
    input  logic                clk_usb,
    input  logic                rst,
    input  logic [`PHASE_W-1:0] phase_target,
    input  logic                psdone,
    output ps_req_t             ps_req,
    output logic                phase_done
);

    phase_state_e               state;
    logic signed [`PHASE_W-1:0] position;   // Steps applied so far
    logic signed [`PHASE_W-1:0] target;
    logic signed [`PHASE_W-1:0] next_pos;   // Position once the pending step lands

    assign target = $signed(phase_target);

    // Direction of the step in flight is held in psincdec
    assign next_pos = ps_req.psincdec ? position + `PHASE_W'(1)
                                      : position - `PHASE_W'(1);

    assign phase_done = (position == target);

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            state    <= PS_IDLE;
            position <= '0;
            ps_req   <= '0;
        end else begin
            ps_req.psen <= 1'b0;     // Single cycle strobe
            case (state)
                PS_IDLE: begin
                    if (position != target) begin
                        ps_req.psen     <= 1'b1;
                        ps_req.psincdec <= (target > position);
                        state           <= PS_STEP;
                    end
                end

                // psen was high in PS_STEP, nothing more until psdone
                PS_STEP, PS_WAIT: begin
                    state <= PS_WAIT;
                    if (psdone) begin
                        position <= next_pos;
                        // Target may have moved while the step was pending
                        if (next_pos != target) begin
                            ps_req.psen     <= 1'b1;
                            ps_req.psincdec <= (target > next_pos);
                            state           <= PS_STEP;
                        end else begin
                            state <= PS_IDLE;
                        end
                    end
                end

                default: state <= PS_IDLE;
            endcase
        end
    end

endmodule

//--- src/drp_access.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module drp_access import clkmgr_pkg::*; (
    input  logic                   clk_usb,
    input  logic                   rst,
    input  logic [`DRP_ADDR_W-1:0] drp_addr,
    input  logic [`DRP_DATA_W-1:0] drp_wdata,
    input  logic                   drp_wr_start,
    input  logic                   drp_rd_start,
    input  drp_rsp_t               drp_rsp,
    output drp_req_t               drp_req,
    output logic [`DRP_DATA_W-1:0] drp_rdata,
    output logic                   drp_busy
);

    drp_state_e             state;
    logic                   den_q;
    logic                   dwe_q;
    logic [`DRP_ADDR_W-1:0] daddr_q;
    logic [`DRP_DATA_W-1:0] di_q;
    logic                   start;

    assign start    = drp_wr_start | drp_rd_start;
    assign drp_busy = (state != DRP_IDLE);  // Drops the cycle after drdy

    always_comb begin
        drp_req = '{daddr: daddr_q, den: den_q, dwe: dwe_q, di: di_q};
    end

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            state <= DRP_IDLE;
            den_q <= 1'b0;
            dwe_q <= 1'b0;
        end else begin
            den_q <= 1'b0;
            dwe_q <= 1'b0;
            case (state)
                DRP_IDLE: begin
                    if (drp_wr_start) begin
                        den_q <= 1'b1;
                        dwe_q <= 1'b1;      // Write strobe rides with den
                        state <= DRP_WAIT_WR;
                    end else if (drp_rd_start) begin
                        den_q <= 1'b1;
                        state <= DRP_WAIT_RD;
                    end
                end
                DRP_WAIT_WR, DRP_WAIT_RD: begin
                    if (drp_rsp.drdy) begin
                        state <= DRP_IDLE;
                    end
                end
                default: state <= DRP_IDLE;
            endcase
        end
    end

    // Address, write word and read capture
    always_ff @(posedge clk_usb) begin
        if (state == DRP_IDLE && start) begin
            daddr_q <= drp_addr;
        end
        if (state == DRP_IDLE && drp_wr_start) begin
            di_q <= drp_wdata;
        end
        if (state == DRP_WAIT_RD && drp_rsp.drdy) begin
            drp_rdata <= drp_rsp.dout;
        end
    end

endmodule

//--- src/clock_source_select.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module clock_source_select import clkmgr_pkg::*; (
    input  logic      clk_usb,
    input  logic      rst,
    input  clk_ctrl_t ctrl,
    output clk_ctrl_t sel,
    output logic      gen_reset
);

    localparam int HOLD_W = $clog2(`SEL_HOLD_CYCLES + 1);

    logic              src_change;
    logic [HOLD_W-1:0] hold_cnt;    // Cycles of generator reset still to go

    // Only the source selects restart the hold, power-downs never do
    assign src_change = (ctrl.adc_source != sel.adc_source) |
                        (ctrl.gen_source != sel.gen_source);

    assign gen_reset = (hold_cnt != '0);

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            sel <= '0;
        end else begin
            sel <= ctrl;    // One register stage for every field
        end
    end

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            hold_cnt <= '0;
        end else if (src_change) begin
            hold_cnt <= HOLD_W'(`SEL_HOLD_CYCLES);  // Restarts on a change mid-hold
        end else if (gen_reset) begin
            hold_cnt <= hold_cnt - HOLD_W'(1);
        end
    end

endmodule

//--- src/clock_manager_top.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module clock_manager_top import clkmgr_pkg::*; (
    input  logic      clk_usb,
    input  logic      rst,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output ps_req_t   ps_req,
    input  logic      psdone,
    output drp_req_t  drp_req,
    input  drp_rsp_t  drp_rsp,
    input  logic      adc_locked,
    input  logic      gen_locked,
    output clk_ctrl_t sel,
    output logic      mmcm_gen_reset
);

    clk_ctrl_t              ctrl;
    logic [`PHASE_W-1:0]    phase_target;
    logic                   phase_done;
    logic [`DRP_ADDR_W-1:0] drp_addr;
    logic [`DRP_DATA_W-1:0] drp_wdata;
    logic [`DRP_DATA_W-1:0] drp_rdata;
    logic                   drp_wr_start;
    logic                   drp_rd_start;
    logic                   drp_reset;
    logic                   drp_busy;
    logic                   gen_reset;

    clkmgr_regs u_regs (
        .clk_usb      (clk_usb),
        .rst          (rst),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .phase_done   (phase_done),
        .drp_busy     (drp_busy),
        .adc_locked   (adc_locked),
        .gen_locked   (gen_locked),
        .drp_rdata    (drp_rdata),
        .ctrl         (ctrl),
        .phase_target (phase_target),
        .drp_addr     (drp_addr),
        .drp_wdata    (drp_wdata),
        .drp_wr_start (drp_wr_start),
        .drp_rd_start (drp_rd_start),
        .drp_reset    (drp_reset)
    );

    phase_shift_ctrl u_phase (
        .clk_usb      (clk_usb),
        .rst          (rst),
        .phase_target (phase_target),
        .psdone       (psdone),
        .ps_req       (ps_req),
        .phase_done   (phase_done)
    );

    drp_access u_drp (
        .clk_usb      (clk_usb),
        .rst          (rst),
        .drp_addr     (drp_addr),
        .drp_wdata    (drp_wdata),
        .drp_wr_start (drp_wr_start),
        .drp_rd_start (drp_rd_start),
        .drp_rsp      (drp_rsp),
        .drp_req      (drp_req),
        .drp_rdata    (drp_rdata),
        .drp_busy     (drp_busy)
    );

    clock_source_select u_src_sel (
        .clk_usb   (clk_usb),
        .rst       (rst),
        .ctrl      (ctrl),
        .sel       (sel),
        .gen_reset (gen_reset)
    );

    // Generator stays in reset for board reset, relock hold or software request
    assign mmcm_gen_reset = rst | gen_reset | drp_reset;

endmodule

//--- verification/clock_manager_asserts.sv
`timescale 1ns/100ps

// Strobe and done handshake, shared by the phase shift and DRP ports
module clock_manager_asserts (
    input logic clk_usb,
    input logic rst,
    input logic strobe,     // psen or den
    input logic done        // psdone or drdy
);

    logic pending;  // Strobe issued, done not yet seen

    always_ff @(posedge clk_usb) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (strobe) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    single_cycle_strobe: assert property (@(posedge clk_usb) disable iff (rst)
        strobe |=> !strobe)
        else $error("strobe held high for more than one cycle");

    no_strobe_before_done: assert property (@(posedge clk_usb) disable iff (rst)
        pending |-> !strobe)
        else $error("strobe reissued before the previous done");

endmodule

bind phase_shift_ctrl clock_manager_asserts u_ps_asserts (
    .clk_usb (clk_usb),
    .rst     (rst),
    .strobe  (ps_req.psen),
    .done    (psdone)
);

bind drp_access clock_manager_asserts u_drp_asserts (
    .clk_usb (clk_usb),
    .rst     (rst),
    .strobe  (drp_req.den),
    .done    (drp_rsp.drdy)
);

//--- verification/clock_manager_tb.sv
`timescale 1ns/100ps
`include "clkmgr_macros.svh"

module clock_manager_tb import clkmgr_pkg::*; ();

    logic      clk_usb;
    logic      rst;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    ps_req_t   ps_req;
    logic      psdone;
    drp_req_t  drp_req;
    drp_rsp_t  drp_rsp;
    logic      adc_locked;
    logic      gen_locked;
    clk_ctrl_t sel;
    logic      mmcm_gen_reset;

    logic [31:0]                seed = 32'hb75f;
    int                         errors = 0;
    int                         checks = 0;
    int                         tests = 0;
    int                         test_mark;
    string                      test_name;
    logic signed [`PHASE_W-1:0] model_pos;     // Generator phase as seen by the model
    int                         ups;
    int                         downs;
    logic [`DRP_DATA_W-1:0]     drp_mem [0:127];

    clock_manager_top uut (.*);

    always #20 clk_usb = ~clk_usb;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};   // High state bits to the bottom
    endfunction

    // Setup cycle then access cycle with the response sampled mid access
    task automatic apb_transfer(input logic write, input logic [`CLKMGR_ADDR_W-1:0] addr,
                                input logic [`CLKMGR_DATA_W-1:0] wdata,
                                output logic [`CLKMGR_DATA_W-1:0] rdata, output logic err);
        apb_req = '{paddr: addr, psel: 1'b1, penable: 1'b0, pwrite: write, pwdata: wdata};
        @(posedge clk_usb);
        #2 apb_req.penable = 1'b1;
        @(negedge clk_usb);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_flag("pready", 1'b1, apb_rsp.pready);
        @(posedge clk_usb);
        #2 apb_req = '0;
    endtask

    task automatic wait_status(input int idx, input logic level, input string what);
        logic [`CLKMGR_DATA_W-1:0] rd;
        logic                      err;
        int                        guard;
        guard = 0;
        apb_transfer(1'b0, REG_STATUS, '0, rd, err);
        while (rd[idx] !== level && guard < 300) begin
            apb_transfer(1'b0, REG_STATUS, '0, rd, err);
            guard++;
        end
        if (rd[idx] !== level) begin
            $display("%s: timed out waiting for %s in the status register", test_name, what);
            errors++;
        end
    endtask

    // Counts high cycles of the generator reset within a bounded window
    task automatic measure_hold(output int cycles);
        int guard;
        cycles = 0;
        guard  = 0;
        while (guard < 40) begin
            @(negedge clk_usb);
            guard++;
            if (mmcm_gen_reset) begin
                cycles++;
            end else if (cycles > 0) begin
                break;
            end
        end
        @(posedge clk_usb);
        #2;
    endtask

    task automatic check_ctrl(input string name, input clk_ctrl_t exp, input clk_ctrl_t act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_phase(input string name, input logic signed [`PHASE_W-1:0] exp,
                               input logic signed [`PHASE_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [`DRP_DATA_W-1:0] exp,
                              input logic [`DRP_DATA_W-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %b, actual %b", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            $display("[ERROR] %s %s: expected %0d, actual %0d", test_name, name, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_mark) begin
            $display("%s: passed", test_name);
        end else begin
            $display("%s: failed with %0d errors", test_name, errors - test_mark);
        end
    endtask

    // Generator phase shift response with psdone 1 to 4 cycles after psen
    always begin
        int   delay;
        logic up;
        @(negedge clk_usb);
        if (ps_req.psen === 1'b1) begin
            up = ps_req.psincdec;
            if (up) begin
                ups++;
            end else begin
                downs++;
            end
            delay = 1 + int'(lcg_next() % 4);
            repeat (delay) @(posedge clk_usb);
            #2 psdone = 1'b1;
            @(posedge clk_usb);
            #2 psdone = 1'b0;
            model_pos = up ? model_pos + `PHASE_W'(1) : model_pos - `PHASE_W'(1);
        end
    end

    // Generator DRP answering den with drdy 1 to 5 cycles later
    always begin
        int                     delay;
        logic [`DRP_ADDR_W-1:0] addr;
        logic                   write;
        logic [`DRP_DATA_W-1:0] wdata;
        @(negedge clk_usb);
        if (drp_req.den === 1'b1) begin
            addr  = drp_req.daddr;
            write = drp_req.dwe;
            wdata = drp_req.di;
            delay = 1 + int'(lcg_next() % 5);
            repeat (delay) @(posedge clk_usb);
            #2;
            if (write) begin
                drp_mem[addr] = wdata;
            end
            drp_rsp = '{dout: drp_mem[addr], drdy: 1'b1};
            @(posedge clk_usb);
            #2 drp_rsp.drdy = 1'b0;
        end
    end

    initial begin
        logic [`CLKMGR_DATA_W-1:0]  rd;
        logic                       err;
        logic [15:0]                val;
        clk_ctrl_t                  exp_ctrl;
        logic signed [`PHASE_W-1:0] tgt;
        logic signed [`PHASE_W-1:0] prev_tgt;
        int                         diff;
        int                         hold;
        logic [`DRP_ADDR_W-1:0]     daddr;
        logic [`DRP_DATA_W-1:0]     dval;

        clk_usb    = 1'b0;
        rst        = 1'b1;
        apb_req    = '0;
        psdone     = 1'b0;
        drp_rsp    = '0;
        adc_locked = 1'b0;
        gen_locked = 1'b0;
        model_pos  = '0;
        ups        = 0;
        downs      = 0;
        for (int i = 0; i < 128; i++) begin
            drp_mem[i] = 16'h5a00 ^ 16'(i * 16'h0123);
        end
        repeat (2) @(posedge clk_usb);
        #2 rst = 1'b0;

        start_test("control_fields");
        for (int i = 0; i < 8; i++) begin
            val      = 16'(lcg_next());
            exp_ctrl = clk_ctrl_t'(val[$bits(clk_ctrl_t)-1:0]);
            apb_transfer(1'b1, REG_CTRL, val, rd, err);
            @(posedge clk_usb);     // sel lands one cycle after the write edge
            #2;
            check_ctrl("sel_output", exp_ctrl, sel);
            apb_transfer(1'b0, REG_CTRL, '0, rd, err);
            check_ctrl("readback", exp_ctrl, clk_ctrl_t'(rd[$bits(clk_ctrl_t)-1:0]));
            check_flag("readback_upper_zero", 1'b1, rd[15:$bits(clk_ctrl_t)] == '0);
        end
        end_test();

        start_test("phase_stepping");
        prev_tgt = '0;
        for (int i = 0; i < 6; i++) begin
            tgt   = `PHASE_W'(int'(lcg_next() % 41) - 20);
            ups   = 0;
            downs = 0;
            apb_transfer(1'b1, REG_PHASE, tgt, rd, err);
            wait_status(0, 1'b1, "phase_done");
            diff = int'(tgt) - int'(prev_tgt);
            check_phase("model_position", tgt, model_pos);
            check_count("increment_pulses", (diff > 0) ? diff : 0, ups);
            check_count("decrement_pulses", (diff < 0) ? -diff : 0, downs);
            prev_tgt = tgt;
        end
        end_test();

        start_test("drp_round_trip");
        for (int i = 0; i < 6; i++) begin
            daddr = `DRP_ADDR_W'(lcg_next());
            dval  = `DRP_DATA_W'(lcg_next());
            apb_transfer(1'b1, REG_DRP_ADDR, 16'(daddr), rd, err);
            apb_transfer(1'b1, REG_DRP_DATA, dval, rd, err);
            wait_status(1, 1'b0, "end of drp write");
            check_data("memory_after_write", dval, drp_mem[daddr]);
            apb_transfer(1'b1, REG_DRP_CMD, 16'h0001, rd, err);
            wait_status(1, 1'b0, "end of drp read");
            apb_transfer(1'b0, REG_DRP_DATA, '0, rd, err);
            check_data("readback", drp_mem[daddr], rd);
        end
        end_test();

        start_test("reset_hold");
        exp_ctrl            = sel;
        exp_ctrl.adc_source = exp_ctrl.adc_source + 3'd1;
        apb_transfer(1'b1, REG_CTRL, 16'(exp_ctrl), rd, err);
        measure_hold(hold);
        check_count("adc_source_hold", `SEL_HOLD_CYCLES, hold);
        exp_ctrl.gen_source = ~exp_ctrl.gen_source;
        apb_transfer(1'b1, REG_CTRL, 16'(exp_ctrl), rd, err);
        measure_hold(hold);
        check_count("gen_source_hold", `SEL_HOLD_CYCLES, hold);
        exp_ctrl.adc_power_down = ~exp_ctrl.adc_power_down;
        exp_ctrl.gen_power_down = ~exp_ctrl.gen_power_down;
        apb_transfer(1'b1, REG_CTRL, 16'(exp_ctrl), rd, err);
        measure_hold(hold);
        check_count("power_down_no_hold", 0, hold);
        end_test();

        start_test("errors_and_status");
        apb_transfer(1'b1, 8'h18 + 8'(lcg_next() % 200), 16'hffff, rd, err);
        check_flag("unmapped_write", 1'b1, err);
        apb_transfer(1'b0, 8'h18 + 8'(lcg_next() % 200), '0, rd, err);
        check_flag("unmapped_read", 1'b1, err);
        check_ctrl("unchanged_sel", exp_ctrl, sel);
        daddr = `DRP_ADDR_W'(lcg_next());
        dval  = `DRP_DATA_W'(lcg_next());
        apb_transfer(1'b1, REG_DRP_ADDR, 16'(daddr), rd, err);
        apb_transfer(1'b1, REG_DRP_DATA, dval, rd, err);
        check_flag("idle_drp_write", 1'b0, err);
        apb_transfer(1'b1, REG_DRP_DATA, ~dval, rd, err);   // Bridge still busy
        check_flag("busy_drp_write", 1'b1, err);
        wait_status(1, 1'b0, "end of drp write");
        check_data("memory_unchanged", dval, drp_mem[daddr]);
        for (int i = 0; i < 4; i++) begin
            val        = 16'(lcg_next());
            adc_locked = val[0];
            gen_locked = val[1];
            apb_transfer(1'b0, REG_STATUS, '0, rd, err);
            check_flag("adc_locked_bit", val[0], rd[2]);
            check_flag("gen_locked_bit", val[1], rd[3]);
        end
        end_test();

        $display("Tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+src
src/clkmgr_pkg.sv
src/clkmgr_regs.sv
src/phase_shift_ctrl.sv
src/drp_access.sv
src/clock_source_select.sv
src/clock_manager_top.sv
verification/clock_manager_asserts.sv
verification/clock_manager_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module clock_manager_tb -Mdir obj_dir

# A failed run still reaches the search below
output=$(./obj_dir/Vclock_manager_tb) || true
echo "$output"

if echo "$output" | grep -q "Finished with no errors"; then
    exit 0
else
    exit 1
fi
